// File: source/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Widths
`define ID_INSTR_W   24
`define ID_ADDR_W    16
`define ID_OPC_W     8
`define ID_GP_W      4
`define ID_AR_W      2
`define ID_CC_W      4
`define ID_IMM12_W   12
`define ID_IMM10_W   10

// Field positions (lsb of each field)
`define ID_OPC_LSB     16
`define ID_TGT_GP_LSB  12
`define ID_SRC_GP_LSB  8
`define ID_SRC_AR_LSB  10
`define ID_TGT_AR_LSB  14
`define ID_CC_UR_LSB   10
`define ID_CC_SO_LSB   12

// Opcodes
`define ID_OPC_MOVUR  8'h00
`define ID_OPC_ADDUR  8'h01
`define ID_OPC_SUBUR  8'h02
`define ID_OPC_ANDUR  8'h03
`define ID_OPC_CMPUR  8'h04
`define ID_OPC_MOVUI  8'h10
`define ID_OPC_ADDUI  8'h11
`define ID_OPC_CMPUI  8'h12
`define ID_OPC_ADDSR  8'h20
`define ID_OPC_SUBSR  8'h21
`define ID_OPC_CMPSR  8'h22
`define ID_OPC_MOVSI  8'h30
`define ID_OPC_ADDSI  8'h31
`define ID_OPC_LDUR   8'h40
`define ID_OPC_STUR   8'h41
`define ID_OPC_LDSO   8'h50
`define ID_OPC_STSO   8'h51
`define ID_OPC_JCCUR  8'h70
`define ID_OPC_JCCUI  8'h71
`define ID_OPC_BCCSO  8'h72

`endif

// File: source/id_pkg.sv
`include "id_params.svh"

package id_pkg;

    // Per-opcode control flags
    typedef struct packed {
        logic sgn_en;
        logic imm_en;
        logic tgt_gp_we;
        logic has_tgt_gp;
        logic has_src_gp;
        logic has_src_ar;
        logic has_tgt_ar;
    } id_flags_t;

    // Register indices, zero when absent
    typedef struct packed {
        logic [`ID_GP_W-1:0] tgt_gp;
        logic [`ID_GP_W-1:0] src_gp;
        logic [`ID_AR_W-1:0] src_ar;
        logic [`ID_AR_W-1:0] tgt_ar;
    } id_regs_t;

    // Immediates and branch condition
    typedef struct packed {
        logic [`ID_IMM12_W-1:0] imm12;
        logic [`ID_IMM10_W-1:0] imm10;
        logic [`ID_CC_W-1:0]    cc;
    } id_imm_t;

    // Full decode stage output
    typedef struct packed {
        logic [`ID_ADDR_W-1:0]  pc;
        logic [`ID_INSTR_W-1:0] instr;
        logic [`ID_OPC_W-1:0]   opc;
        id_flags_t              flags;
        id_regs_t               regs;
        id_imm_t                imm;
    } id_decoded_t;

endpackage

// File: source/id_opc_classify.sv
`timescale 1ns/1ns
`include "id_params.svh"

module id_opc_classify (
    input  logic [`ID_OPC_W-1:0] opc,
    output id_pkg::id_flags_t    flags
);
    import id_pkg::*;

    always_comb begin
        // Undefined opcodes fall through with no flags
        flags = '0;
        case (opc)
            `ID_OPC_MOVUR, `ID_OPC_ADDUR, `ID_OPC_SUBUR, `ID_OPC_ANDUR: begin
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_src_gp = 1'b1;
            end
            `ID_OPC_CMPUR: begin
                flags.has_tgt_gp = 1'b1;
                flags.has_src_gp = 1'b1;
            end
            `ID_OPC_MOVUI, `ID_OPC_ADDUI: begin
                flags.imm_en     = 1'b1;
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
            end
            `ID_OPC_CMPUI: begin
                flags.imm_en     = 1'b1;
                flags.has_tgt_gp = 1'b1;
            end
            `ID_OPC_ADDSR, `ID_OPC_SUBSR: begin
                flags.sgn_en     = 1'b1;
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_src_gp = 1'b1;
            end
            `ID_OPC_CMPSR: begin
                flags.sgn_en     = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_src_gp = 1'b1;
            end
            `ID_OPC_MOVSI, `ID_OPC_ADDSI: begin
                flags.sgn_en     = 1'b1;
                flags.imm_en     = 1'b1;
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
            end
            // Address register based memory ops
            `ID_OPC_LDUR: begin
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_src_ar = 1'b1;
            end
            `ID_OPC_STUR: begin
                flags.has_tgt_gp = 1'b1;
                flags.has_src_gp = 1'b1;
                flags.has_tgt_ar = 1'b1;
            end
            // Base plus signed offset
            `ID_OPC_LDSO: begin
                flags.sgn_en     = 1'b1;
                flags.imm_en     = 1'b1;
                flags.tgt_gp_we  = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_src_ar = 1'b1;
            end
            `ID_OPC_STSO: begin
                flags.sgn_en     = 1'b1;
                flags.imm_en     = 1'b1;
                flags.has_tgt_gp = 1'b1;
                flags.has_tgt_ar = 1'b1;
            end
            // Control flow
            `ID_OPC_JCCUR: flags.has_tgt_ar = 1'b1;
            `ID_OPC_JCCUI: flags.imm_en = 1'b1;
            `ID_OPC_BCCSO: begin
                flags.sgn_en = 1'b1;
                flags.imm_en = 1'b1;
            end
            default: flags = '0;
        endcase
    end

endmodule

// File: source/id_imm_select.sv
`timescale 1ns/1ns
`include "id_params.svh"

module id_imm_select (
    input  logic [`ID_INSTR_W-1:0] instr,
    output id_pkg::id_imm_t        imm
);
    import id_pkg::*;

    logic [`ID_OPC_W-1:0] opc;

    assign opc = instr[`ID_OPC_LSB +: `ID_OPC_W];

    always_comb begin
        imm = '0;
        case (opc)
            `ID_OPC_MOVUI, `ID_OPC_ADDUI, `ID_OPC_CMPUI,
            `ID_OPC_MOVSI, `ID_OPC_ADDSI: begin
                imm.imm12 = instr[`ID_IMM12_W-1:0];
            end
            // Offset only for base plus offset memory ops
            `ID_OPC_LDSO, `ID_OPC_STSO: begin
                imm.imm10 = instr[`ID_IMM10_W-1:0];
            end
            // Register jump keeps cc lower, below the AR field
            `ID_OPC_JCCUR: begin
                imm.cc = instr[`ID_CC_UR_LSB +: `ID_CC_W];
            end
            `ID_OPC_JCCUI, `ID_OPC_BCCSO: begin
                imm.imm12 = instr[`ID_IMM12_W-1:0];
                imm.cc    = instr[`ID_CC_SO_LSB +: `ID_CC_W];
            end
            default: imm = '0;
        endcase
    end

endmodule

// File: source/id_reg_fields.sv
`timescale 1ns/1ns
`include "id_params.svh"

module id_reg_fields (
    input  logic [`ID_INSTR_W-1:0] instr,
    input  id_pkg::id_flags_t      flags,
    output id_pkg::id_regs_t       regs
);
    import id_pkg::*;

    // Raw fields at their fixed encoding positions
    logic [`ID_GP_W-1:0] raw_tgt_gp;
    logic [`ID_GP_W-1:0] raw_src_gp;
    logic [`ID_AR_W-1:0] raw_src_ar;
    logic [`ID_AR_W-1:0] raw_tgt_ar;

    assign raw_tgt_gp = instr[`ID_TGT_GP_LSB +: `ID_GP_W];
    assign raw_src_gp = instr[`ID_SRC_GP_LSB +: `ID_GP_W];
    assign raw_src_ar = instr[`ID_SRC_AR_LSB +: `ID_AR_W];
    assign raw_tgt_ar = instr[`ID_TGT_AR_LSB +: `ID_AR_W];

    // Fields overlap between formats, so only present ones pass
    always_comb begin
        regs = '0;
        if (flags.has_tgt_gp) begin
            regs.tgt_gp = raw_tgt_gp;
        end
        if (flags.has_src_gp) begin
            regs.src_gp = raw_src_gp;
        end
        if (flags.has_src_ar) begin
            regs.src_ar = raw_src_ar;
        end
        if (flags.has_tgt_ar) begin
            regs.tgt_ar = raw_tgt_ar;
        end
    end

endmodule

// File: source/stg_id.sv
`timescale 1ns/1ns
`include "id_params.svh"

module stg_id (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  logic                   instr_strobe,
    input  logic [`ID_ADDR_W-1:0]  pc,
    input  logic [`ID_INSTR_W-1:0] instr,
    input  logic                   flush,
    input  logic                   stall,
    output id_pkg::id_decoded_t    decoded,
    output logic                   decoded_valid
);
    import id_pkg::*;

    logic [`ID_OPC_W-1:0] opc;
    id_flags_t            flags;
    id_imm_t              imm;
    id_regs_t             regs;
    id_decoded_t          decoded_next;

    assign opc = instr[`ID_OPC_LSB +: `ID_OPC_W];

    id_opc_classify i_id_opc_classify (
        .opc   (opc),
        .flags (flags)
    );

    id_imm_select i_id_imm_select (
        .instr (instr),
        .imm   (imm)
    );

    id_reg_fields i_id_reg_fields (
        .instr (instr),
        .flags (flags),
        .regs  (regs)
    );

    always_comb begin
        decoded_next.pc    = pc;
        decoded_next.instr = instr;
        decoded_next.opc   = opc;
        decoded_next.flags = flags;
        decoded_next.regs  = regs;
        decoded_next.imm   = imm;
    end

    // Flush beats stall, stall beats a new strobe
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            decoded       <= '0;
            decoded_valid <= 1'b0;
        end else if (flush) begin
            decoded       <= '0;
            decoded_valid <= 1'b0;
        end else if (!stall) begin
            decoded_valid <= instr_strobe;
            if (instr_strobe) begin
                decoded <= decoded_next;
            end
        end
    end

    // A flushed slot never shows up downstream
    a_flush_clears: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        flush |=> (!decoded_valid && decoded == '0)
    );

    // Stage is frozen while stalled
    a_stall_holds: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> ($stable(decoded) && $stable(decoded_valid))
    );

    // Write enable without a target field would write a random register
    a_we_has_tgt: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        decoded.flags.tgt_gp_we |-> decoded.flags.has_tgt_gp
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic iw_clk,
    output logic iw_rst
);
    localparam int half_period = 2;
    localparam int rst_cycles  = 5;

    initial begin
        iw_clk = 1'b0;
        forever #(half_period) iw_clk = ~iw_clk;
    end

    // Release on a falling edge, away from the flops
    initial begin
        iw_rst = 1'b1;
        repeat (rst_cycles) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
    end

endmodule

// File: tb/tb_decode_ref.svh
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// Opcode belongs to the supported subset
function automatic logic opc_defined(input logic [7:0] opc);
    logic [3:0] cls;
    logic [3:0] idx;
    cls = opc[7:4];
    idx = opc[3:0];
    case (cls)
        4'h0: opc_defined = (idx <= 4'h4);
        4'h1: opc_defined = (idx <= 4'h2);
        4'h2: opc_defined = (idx <= 4'h2);
        4'h3, 4'h4, 4'h5: opc_defined = (idx <= 4'h1);
        4'h7: opc_defined = (idx <= 4'h2);
        default: opc_defined = 1'b0;
    endcase
endfunction

// Expected stage output for one instruction
function automatic id_decoded_t decode_ref(input logic [15:0] pc, input logic [23:0] instr);
    id_decoded_t d;
    logic [7:0]  opc;
    logic [3:0]  cls;
    logic        is_cmp;
    logic        is_ld;
    logic        is_st;
    d = '0;
    opc = instr[23:16];
    cls = opc[7:4];
    d.pc = pc;
    d.instr = instr;
    d.opc = opc;
    if (opc_defined(opc)) begin
        is_cmp = (opc == 8'h04) || (opc == 8'h12) || (opc == 8'h22);
        is_ld = (opc == 8'h40) || (opc == 8'h50);
        is_st = (opc == 8'h41) || (opc == 8'h51);

        d.flags.sgn_en = (cls == 4'h2) || (cls == 4'h3) || (cls == 4'h5) || (opc == 8'h72);
        d.flags.imm_en = (cls == 4'h1) || (cls == 4'h3) || (cls == 4'h5)
                         || (opc == 8'h71) || (opc == 8'h72);
        d.flags.tgt_gp_we = ((cls <= 4'h3) && !is_cmp) || is_ld;
        d.flags.has_tgt_gp = d.flags.tgt_gp_we || is_cmp || is_st;
        d.flags.has_src_gp = (cls == 4'h0) || (cls == 4'h2) || (opc == 8'h41);
        d.flags.has_src_ar = is_ld;
        d.flags.has_tgt_ar = (opc == 8'h41) || (opc == 8'h51) || (opc == 8'h70);

        if (d.flags.has_tgt_gp)
            d.regs.tgt_gp = instr[15:12];
        if (d.flags.has_src_gp)
            d.regs.src_gp = instr[11:8];
        if (d.flags.has_src_ar)
            d.regs.src_ar = instr[11:10];
        if (d.flags.has_tgt_ar)
            d.regs.tgt_ar = instr[15:14];

        if ((cls == 4'h1) || (cls == 4'h3) || (opc == 8'h71) || (opc == 8'h72))
            d.imm.imm12 = instr[11:0];
        if (cls == 4'h5)
            d.imm.imm10 = instr[9:0];
        if (opc == 8'h70)
            d.imm.cc = instr[13:10];
        else if ((opc == 8'h71) || (opc == 8'h72))
            d.imm.cc = instr[15:12];
    end
    decode_ref = d;
endfunction

`endif

// File: tb/tb_stg_id.sv
`timescale 1ns/1ns
`include "id_params.svh"

module tb_stg_id;
    import id_pkg::*;

    `include "tb_decode_ref.svh"

    localparam int n_random       = 400;
    localparam int n_directed     = 100;
    localparam int timeout_cycles = 4 * (n_random + n_directed);

    logic                   iw_clk;
    logic                   iw_rst;
    logic                   instr_strobe;
    logic [`ID_ADDR_W-1:0]  pc;
    logic [`ID_INSTR_W-1:0] instr;
    logic                   flush;
    logic                   stall;
    id_decoded_t            decoded;
    logic                   decoded_valid;

    // Expected state and what the stage saw at the last rising edge
    id_decoded_t exp_decoded;
    logic        exp_valid;
    id_decoded_t held_decoded;
    logic        held_valid;
    logic        last_rst;
    logic        last_flush;
    logic        last_stall;

    int          cycles = 0;
    int          n_valid_checks = 0;
    int          n_stall_checks = 0;
    int          n_flush_checks = 0;
    int          n_undef_checks = 0;
    integer      seed;
    logic [7:0]  opc_list [20];

    tb_clk_gen i_tb_clk_gen (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst)
    );

    stg_id i_stg_id (
        .iw_clk        (iw_clk),
        .iw_rst        (iw_rst),
        .instr_strobe  (instr_strobe),
        .pc            (pc),
        .instr         (instr),
        .flush         (flush),
        .stall         (stall),
        .decoded       (decoded),
        .decoded_valid (decoded_valid)
    );

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string got, input string exp);
        stop_failed($sformatf("CHECK FAILED at %0t ns: %s is %s, expected %s",
                              $time, name, got, exp));
    endtask

    function automatic logic [23:0] rand_instr(input logic [7:0] opc);
        rand_instr = {opc, 16'($random(seed))};
    endfunction

    task automatic drive(input logic strobe, input logic stl, input logic fls,
                         input logic [23:0] ins);
        @(negedge iw_clk);
        instr_strobe = strobe;
        stall = stl;
        flush = fls;
        pc = 16'($random(seed));
        instr = ins;
    endtask

    // Stage behaviour as the register rules give it
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            exp_decoded <= '0;
            exp_valid   <= 1'b0;
        end else if (flush) begin
            exp_decoded <= '0;
            exp_valid   <= 1'b0;
        end else if (!stall) begin
            exp_valid <= instr_strobe;
            if (instr_strobe)
                exp_decoded <= decode_ref(pc, instr);
        end
    end

    always @(posedge iw_clk) begin
        last_rst   <= iw_rst;
        last_flush <= flush;
        last_stall <= stall;
    end

    always @(posedge iw_clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            stop_failed($sformatf("Timeout: no end of test after %0d cycles", cycles));
    end

    // Outputs are settled half a cycle after the rising edge
    always @(negedge iw_clk) begin
        assert (decoded_valid == exp_valid)
            else report_mismatch("decoded_valid", $sformatf("%b", decoded_valid),
                                 $sformatf("%b", exp_valid));
        assert (decoded == exp_decoded)
            else report_mismatch("decoded", $sformatf("%h", decoded),
                                 $sformatf("%h", exp_decoded));
        if (last_rst || last_flush) begin
            if (last_flush)
                n_flush_checks++;
            assert (!decoded_valid)
                else report_mismatch("decoded_valid", $sformatf("%b", decoded_valid), "0");
            assert (decoded == '0)
                else report_mismatch("decoded", $sformatf("%h", decoded), "0");
        end
        if (last_stall && !last_flush && !last_rst) begin
            n_stall_checks++;
            assert (decoded == held_decoded)
                else report_mismatch("decoded", $sformatf("%h", decoded),
                                     $sformatf("%h", held_decoded));
            assert (decoded_valid == held_valid)
                else report_mismatch("decoded_valid", $sformatf("%b", decoded_valid),
                                     $sformatf("%b", held_valid));
        end
        if (decoded_valid) begin
            n_valid_checks++;
            assert (!decoded.flags.tgt_gp_we || decoded.flags.has_tgt_gp)
                else report_mismatch("decoded.flags.has_tgt_gp", "0", "1");
        end
        if (decoded_valid && !opc_defined(decoded.opc)) begin
            n_undef_checks++;
            assert (decoded.flags == '0 && decoded.regs == '0 && decoded.imm == '0)
                else report_mismatch("decoded.flags/regs/imm",
                                     $sformatf("%h/%h/%h", decoded.flags, decoded.regs,
                                               decoded.imm), "0/0/0");
        end
        held_decoded = decoded;
        held_valid = decoded_valid;
    end

    initial begin
        int          i;
        int          idx;
        logic [31:0] r;
        logic [7:0]  opc;

        seed = 32'h538c47c9;
        instr_strobe = 1'b0;
        pc = '0;
        instr = '0;
        flush = 1'b0;
        stall = 1'b0;

        opc_list[0]  = `ID_OPC_MOVUR;
        opc_list[1]  = `ID_OPC_ADDUR;
        opc_list[2]  = `ID_OPC_SUBUR;
        opc_list[3]  = `ID_OPC_ANDUR;
        opc_list[4]  = `ID_OPC_CMPUR;
        opc_list[5]  = `ID_OPC_MOVUI;
        opc_list[6]  = `ID_OPC_ADDUI;
        opc_list[7]  = `ID_OPC_CMPUI;
        opc_list[8]  = `ID_OPC_ADDSR;
        opc_list[9]  = `ID_OPC_SUBSR;
        opc_list[10] = `ID_OPC_CMPSR;
        opc_list[11] = `ID_OPC_MOVSI;
        opc_list[12] = `ID_OPC_ADDSI;
        opc_list[13] = `ID_OPC_LDUR;
        opc_list[14] = `ID_OPC_STUR;
        opc_list[15] = `ID_OPC_LDSO;
        opc_list[16] = `ID_OPC_STSO;
        opc_list[17] = `ID_OPC_JCCUR;
        opc_list[18] = `ID_OPC_JCCUI;
        opc_list[19] = `ID_OPC_BCCSO;

        @(negedge iw_rst);

        // Every defined opcode, back to back, then a gap
        for (i = 0; i < 20; i++)
            drive(1'b1, 1'b0, 1'b0, rand_instr(opc_list[i]));
        drive(1'b0, 1'b0, 1'b0, rand_instr(opc_list[3]));
        drive(1'b0, 1'b0, 1'b0, rand_instr(opc_list[7]));

        // Holes in the opcode map
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h05));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h13));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h23));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h42));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h60));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'h73));
        drive(1'b1, 1'b0, 1'b0, rand_instr(8'hff));

        // Stall ignores strobe and a changing instruction
        drive(1'b1, 1'b0, 1'b0, rand_instr(`ID_OPC_ADDUR));
        repeat (3) drive(1'b1, 1'b1, 1'b0, rand_instr(opc_list[15]));
        drive(1'b0, 1'b1, 1'b0, rand_instr(opc_list[18]));
        drive(1'b1, 1'b0, 1'b0, rand_instr(opc_list[16]));

        // Flush alone and against stall and strobe
        drive(1'b1, 1'b1, 1'b1, rand_instr(opc_list[12]));
        drive(1'b1, 1'b0, 1'b0, rand_instr(opc_list[13]));
        drive(1'b1, 1'b0, 1'b1, rand_instr(opc_list[17]));
        drive(1'b0, 1'b0, 1'b1, rand_instr(opc_list[2]));
        drive(1'b1, 1'b0, 1'b0, rand_instr(opc_list[19]));

        for (i = 0; i < n_random; i++) begin
            r = $random(seed);
            idx = int'(r[15:8]) % 20;
            // Mostly defined opcodes, now and then any byte
            if (r[2:0] != 3'd0)
                opc = opc_list[idx];
            else
                opc = r[23:16];
            drive(r[3] | r[4], r[7:5] == 3'd0, r[31:28] == 4'd0, rand_instr(opc));
        end
        repeat (3) drive(1'b0, 1'b0, 1'b0, rand_instr(8'h00));
        @(negedge iw_clk);

        if (n_valid_checks == 0 || n_stall_checks == 0 || n_flush_checks == 0
            || n_undef_checks == 0) begin
            stop_failed("Some checks were never reached by the stimulus");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+source
+incdir+tb
source/id_pkg.sv
source/id_opc_classify.sv
source/id_imm_select.sv
source/id_reg_fields.sv
source/stg_id.sv
tb/tb_clk_gen.sv
tb/tb_stg_id.sv

// File: Makefile
SRCS := $(wildcard source/*.sv source/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: obj_dir/Vtb_stg_id

obj_dir/Vtb_stg_id: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_stg_id -f build.f -Mdir obj_dir -o Vtb_stg_id

run: obj_dir/Vtb_stg_id
	./obj_dir/Vtb_stg_id

clean:
	rm -rf obj_dir
